/* design/mipsPkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared definitions for the MIPS32 decode/execute pipeline
// word width, opcode and ALU function enums
// decode control struct
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mipsPkg;

    localparam int wordW = 32;

    // function field of mul under SPECIAL2
    localparam logic [5:0] special2Mul = 6'h02;

    typedef enum logic [5:0] {
        RTYPE    = 6'h00,
        J        = 6'h02,
        JAL      = 6'h03,
        BEQ      = 6'h04,
        BNE      = 6'h05,
        ADDIU    = 6'h09,
        SLTI     = 6'h0a,
        ANDI     = 6'h0c,
        ORI      = 6'h0d,
        XORI     = 6'h0e,
        LUI      = 6'h0f,
        SPECIAL2 = 6'h1c,
        LW       = 6'h23,
        SW       = 6'h2b
    } opcodeE;

    // R-type function codes, MUL moved to a free slot
    typedef enum logic [5:0] {
        SLL  = 6'h00,
        SRL  = 6'h02,
        SRA  = 6'h03,
        MUL  = 6'h18,
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        NOR  = 6'h27,
        SLT  = 6'h2a
    } funcE;

    typedef struct packed {
        logic branch;
        logic branchNe;
        logic jump;
        logic link;
        logic memRead;
        logic memtoReg;
        logic memWrite;
        logic aluSrc;
        logic regWrite;
        logic regDst;
        logic mulOp;
        logic shiftImm;
        logic luiSel;
        logic unsignedImm;
        funcE aluFunc;
    } ctrlT;

endpackage

/* design/decExIf.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode to execute pipeline register bundle
// modport dec drives, modport ex reads
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface decExIf;

    logic                       valid;
    mipsPkg::ctrlT              ctrl;
    logic [4:0]                 rsAddr;
    logic [4:0]                 rtAddr;
    logic [mipsPkg::wordW-1:0]  rsData;
    logic [mipsPkg::wordW-1:0]  rtData;
    logic [mipsPkg::wordW-1:0]  immData;
    logic [4:0]                 shamt;
    // final write register, rt, rd or r31
    logic [4:0]                 destAddr;
    logic [mipsPkg::wordW-1:0]  pcInc;
    logic [mipsPkg::wordW-1:0]  jumpTarget;

    modport dec (
        output valid, ctrl, rsAddr, rtAddr, rsData, rtData,
               immData, shamt, destAddr, pcInc, jumpTarget
    );

    modport ex (
        input  valid, ctrl, rsAddr, rtAddr, rsData, rtData,
               immData, shamt, destAddr, pcInc, jumpTarget
    );

endinterface

/* design/mipsControl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main and function decoder
// opcode and function code to control struct
// unsupported encodings decode as a no-op
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mipsControl (
    input  mipsPkg::opcodeE opCode,
    input  logic [5:0]      funcCode,
    output mipsPkg::ctrlT   ctrl
);

    always_comb begin
        ctrl = '0;
        case (opCode)
            mipsPkg::RTYPE: begin
                case (funcCode)
                    mipsPkg::SLL, mipsPkg::SRL, mipsPkg::SRA: begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.shiftImm = 1'b1;
                        ctrl.aluFunc  = mipsPkg::funcE'(funcCode);
                    end
                    mipsPkg::ADDU, mipsPkg::SUBU, mipsPkg::AND, mipsPkg::OR,
                    mipsPkg::XOR, mipsPkg::NOR, mipsPkg::SLT: begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.aluFunc  = mipsPkg::funcE'(funcCode);
                    end
                    default: ctrl = '0;
                endcase
            end
            mipsPkg::SPECIAL2: begin
                if (funcCode == mipsPkg::special2Mul) begin
                    ctrl.regDst   = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.mulOp    = 1'b1;
                    ctrl.aluFunc  = mipsPkg::MUL;
                end
            end
            mipsPkg::ADDIU: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluFunc  = mipsPkg::ADDU;
            end
            mipsPkg::SLTI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluFunc  = mipsPkg::SLT;
            end
            mipsPkg::ANDI, mipsPkg::ORI, mipsPkg::XORI: begin
                ctrl.aluSrc      = 1'b1;
                ctrl.regWrite    = 1'b1;
                ctrl.unsignedImm = 1'b1;
                if (opCode == mipsPkg::ANDI) begin
                    ctrl.aluFunc = mipsPkg::AND;
                end else if (opCode == mipsPkg::ORI) begin
                    ctrl.aluFunc = mipsPkg::OR;
                end else begin
                    ctrl.aluFunc = mipsPkg::XOR;
                end
            end
            // rs is r0 for lui, so or passes the shifted immediate
            mipsPkg::LUI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.luiSel   = 1'b1;
                ctrl.aluFunc  = mipsPkg::OR;
            end
            mipsPkg::LW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memtoReg = 1'b1;
                ctrl.aluFunc  = mipsPkg::ADDU;
            end
            mipsPkg::SW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluFunc  = mipsPkg::ADDU;
            end
            mipsPkg::BEQ, mipsPkg::BNE: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = (opCode == mipsPkg::BNE);
                ctrl.aluFunc  = mipsPkg::SUBU;
            end
            mipsPkg::J: begin
                ctrl.jump = 1'b1;
            end
            mipsPkg::JAL: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

/* design/regFile.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32 register file, two read ports, one write port
// r0 reads zero, write data bypasses to the read ports
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module regFile (
    input  logic                      Clock,
    input  logic                      rstN,
    input  logic                      wbWrite,
    input  logic [4:0]                wbAddr,
    input  logic [mipsPkg::wordW-1:0] wbData,
    input  logic [4:0]                rsAddr,
    input  logic [4:0]                rtAddr,
    output logic [mipsPkg::wordW-1:0] rsData,
    output logic [mipsPkg::wordW-1:0] rtData
);

    logic [mipsPkg::wordW-1:0] regs [32];

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite && wbAddr != 5'd0) begin
            regs[wbAddr] <= wbData;
        end
    end

    // write-through so the stage two behind needs no forwarding
    always_comb begin
        if (rsAddr == 5'd0) begin
            rsData = '0;
        end else if (wbWrite && wbAddr == rsAddr) begin
            rsData = wbData;
        end else begin
            rsData = regs[rsAddr];
        end

        if (rtAddr == 5'd0) begin
            rtData = '0;
        end else if (wbWrite && wbAddr == rtAddr) begin
            rtData = wbData;
        end else begin
            rtData = regs[rtAddr];
        end
    end

endmodule

/* design/decodeStage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage
// control decode, register read, immediate forming,
// destination select and the decode/execute register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decodeStage (
    input  logic                      Clock,
    input  logic                      rstN,
    input  logic [mipsPkg::wordW-1:0] instr,
    input  logic                      instrValid,
    input  logic [mipsPkg::wordW-1:0] pcInc,
    input  logic                      wbWrite,
    input  logic [4:0]                wbAddr,
    input  logic [mipsPkg::wordW-1:0] wbData,
    decExIf.dec                       dx
);

    logic [4:0]                rsAddr;
    logic [4:0]                rtAddr;
    logic [4:0]                rdAddr;
    logic [15:0]               imm16;
    logic [mipsPkg::wordW-1:0] rsData;
    logic [mipsPkg::wordW-1:0] rtData;
    logic [mipsPkg::wordW-1:0] immData;
    logic [4:0]                destAddr;
    mipsPkg::ctrlT             ctrlDec;
    mipsPkg::ctrlT             ctrlGated;

    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];
    assign rdAddr = instr[15:11];
    assign imm16  = instr[15:0];

    mipsControl uControl (
        .opCode  (mipsPkg::opcodeE'(instr[31:26])),
        .funcCode(instr[5:0]),
        .ctrl    (ctrlDec)
    );

    regFile uRegFile (
        .Clock  (Clock),
        .rstN   (rstN),
        .wbWrite(wbWrite),
        .wbAddr (wbAddr),
        .wbData (wbData),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsData (rsData),
        .rtData (rtData)
    );

    // lui places the field high, logic ops zero-extend, rest sign-extend
    assign immData = ctrlDec.luiSel      ? {imm16, 16'h0000} :
                     ctrlDec.unsignedImm ? {16'h0000, imm16} :
                                           {{16{imm16[15]}}, imm16};

    assign destAddr = ctrlDec.link   ? 5'd31  :
                      ctrlDec.regDst ? rdAddr : rtAddr;

    // writes to r0 are dropped here, e.g. the sll nop
    always_comb begin
        ctrlGated          = ctrlDec;
        ctrlGated.regWrite = ctrlDec.regWrite && (destAddr != 5'd0);
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            dx.valid <= 1'b0;
            dx.ctrl  <= '0;
        end else begin
            dx.valid <= instrValid;
            dx.ctrl  <= instrValid ? ctrlGated : '0;
        end
    end

    always_ff @(posedge Clock) begin
        dx.rsAddr     <= rsAddr;
        dx.rtAddr     <= rtAddr;
        dx.rsData     <= rsData;
        dx.rtData     <= rtData;
        dx.immData    <= immData;
        dx.shamt      <= instr[10:6];
        dx.destAddr   <= destAddr;
        dx.pcInc      <= pcInc;
        dx.jumpTarget <= {pcInc[31:28], instr[25:0], 2'b00};
    end

endmodule

/* design/executeStage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage
// operand forwarding, ALU, shifter, low-word multiply
// word data memory, branch and jump resolution
// write-back, store and redirect output registers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module executeStage #(
    parameter int dmemWords = 64
) (
    input  logic                      Clock,
    input  logic                      rstN,
    decExIf.ex                        dx,
    output logic                      wbValid,
    output logic                      wbWrite,
    output logic [4:0]                wbAddr,
    output logic [mipsPkg::wordW-1:0] wbData,
    output logic                      memWrite,
    output logic [mipsPkg::wordW-1:0] memAddr,
    output logic [mipsPkg::wordW-1:0] memWData,
    output logic                      redirect,
    output logic [mipsPkg::wordW-1:0] redirectPc
);

    localparam int idxW = $clog2(dmemWords);

    logic [mipsPkg::wordW-1:0] dmem [dmemWords];

    logic [mipsPkg::wordW-1:0] opA;
    logic [mipsPkg::wordW-1:0] fwdB;
    logic [mipsPkg::wordW-1:0] opB;
    logic [mipsPkg::wordW-1:0] aluRes;
    logic [mipsPkg::wordW-1:0] shiftRes;
    logic [mipsPkg::wordW-1:0] product;
    logic [mipsPkg::wordW-1:0] result;
    logic [mipsPkg::wordW-1:0] loadData;
    logic [mipsPkg::wordW-1:0] wbDataNext;
    logic [mipsPkg::wordW-1:0] branchTarget;
    logic [idxW-1:0]           memIdx;
    logic                      taken;

    // the write-back register is the only pending write
    assign opA  = (wbWrite && wbAddr == dx.rsAddr) ? wbData : dx.rsData;
    assign fwdB = (wbWrite && wbAddr == dx.rtAddr) ? wbData : dx.rtData;
    assign opB  = dx.ctrl.aluSrc ? dx.immData : fwdB;

    always_comb begin
        case (dx.ctrl.aluFunc)
            mipsPkg::ADDU: aluRes = opA + opB;
            mipsPkg::SUBU: aluRes = opA - opB;
            mipsPkg::AND:  aluRes = opA & opB;
            mipsPkg::OR:   aluRes = opA | opB;
            mipsPkg::XOR:  aluRes = opA ^ opB;
            mipsPkg::NOR:  aluRes = ~(opA | opB);
            mipsPkg::SLT:  aluRes = {{(mipsPkg::wordW-1){1'b0}}, $signed(opA) < $signed(opB)};
            default:       aluRes = '0;
        endcase
    end

    always_comb begin
        case (dx.ctrl.aluFunc)
            mipsPkg::SLL: shiftRes = opB << dx.shamt;
            mipsPkg::SRL: shiftRes = opB >> dx.shamt;
            mipsPkg::SRA: shiftRes = $signed(opB) >>> dx.shamt;
            default:      shiftRes = '0;
        endcase
    end

    // low word is the same for signed and unsigned operands
    assign product = opA * opB;

    assign result = dx.ctrl.mulOp    ? product  :
                    dx.ctrl.shiftImm ? shiftRes : aluRes;

    // word index, byte offset dropped
    assign memIdx   = aluRes[idxW+1:2];
    assign loadData = dx.ctrl.memRead ? dmem[memIdx] : '0;

    always_ff @(posedge Clock) begin
        if (dx.ctrl.memWrite) begin
            dmem[memIdx] <= fwdB;
        end
    end

    assign wbDataNext = dx.ctrl.link     ? dx.pcInc + 32'd4 :
                        dx.ctrl.memtoReg ? loadData         : result;

    // beq/bne compare through the subtract
    assign taken        = dx.ctrl.branch && ((aluRes == '0) ^ dx.ctrl.branchNe);
    assign branchTarget = dx.pcInc + {dx.immData[29:0], 2'b00};

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            wbValid  <= 1'b0;
            wbWrite  <= 1'b0;
            memWrite <= 1'b0;
            redirect <= 1'b0;
        end else begin
            wbValid  <= dx.valid;
            wbWrite  <= dx.ctrl.regWrite;
            memWrite <= dx.ctrl.memWrite;
            redirect <= taken || dx.ctrl.jump;
        end
    end

    always_ff @(posedge Clock) begin
        wbAddr     <= dx.destAddr;
        wbData     <= wbDataNext;
        memAddr    <= aluRes;
        memWData   <= fwdB;
        redirectPc <= dx.ctrl.jump ? dx.jumpTarget : branchTarget;
    end

endmodule

/* design/mipsCore.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode/execute half of a MIPS32 integer pipeline
// decode stage, execute stage and the bundle between them
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mipsCore #(
    parameter int dmemWords = 64
) (
    input  logic                      Clock,
    input  logic                      rstN,
    input  logic [mipsPkg::wordW-1:0] instr,
    input  logic                      instrValid,
    input  logic [mipsPkg::wordW-1:0] pcInc,
    output logic                      wbValid,
    output logic                      wbWrite,
    output logic [4:0]                wbAddr,
    output logic [mipsPkg::wordW-1:0] wbData,
    output logic                      memWrite,
    output logic [mipsPkg::wordW-1:0] memAddr,
    output logic [mipsPkg::wordW-1:0] memWData,
    output logic                      redirect,
    output logic [mipsPkg::wordW-1:0] redirectPc
);

    decExIf dxBus ();

    // write-back outputs also close the loop into the register file
    decodeStage uDecode (
        .Clock     (Clock),
        .rstN      (rstN),
        .instr     (instr),
        .instrValid(instrValid),
        .pcInc     (pcInc),
        .wbWrite   (wbWrite),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .dx        (dxBus.dec)
    );

    executeStage #(
        .dmemWords(dmemWords)
    ) uExecute (
        .Clock     (Clock),
        .rstN      (rstN),
        .dx        (dxBus.ex),
        .wbValid   (wbValid),
        .wbWrite   (wbWrite),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .memWrite  (memWrite),
        .memAddr   (memAddr),
        .memWData  (memWData),
        .redirect  (redirect),
        .redirectPc(redirectPc)
    );

endmodule

/* test/mipsCore_sva.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent assertions on the mipsCore outputs
// reset state of the strobes, write-back consistency
// bind of the checker into mipsCore
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mipsCore_sva (
    input logic       Clock,
    input logic       rstN,
    input logic       wbValid,
    input logic       wbWrite,
    input logic [4:0] wbAddr,
    input logic       memWrite,
    input logic       redirect
);

    // strobes leave reset low
    property resetClears;
        @(posedge Clock) !rstN |=> !(wbValid || wbWrite || memWrite || redirect);
    endproperty

    property writeNeedsValid;
        @(posedge Clock) disable iff (!rstN) wbWrite |-> wbValid;
    endproperty

    // the decoder drops writes to r0
    property noZeroWrite;
        @(posedge Clock) disable iff (!rstN) wbWrite |-> (wbAddr != 5'd0);
    endproperty

    aResetClears: assert property (resetClears)
        else $error("output strobe high in the cycle after reset");
    aWriteNeedsValid: assert property (writeNeedsValid)
        else $error("wbWrite high while wbValid is low");
    aNoZeroWrite: assert property (noZeroWrite)
        else $error("register write to r0 reached the outputs");

endmodule

bind mipsCore mipsCore_sva uMipsCoreSva (
    .Clock   (Clock),
    .rstN    (rstN),
    .wbValid (wbValid),
    .wbWrite (wbWrite),
    .wbAddr  (wbAddr),
    .memWrite(memWrite),
    .redirect(redirect)
);

/* test/tb_mipsCore.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the mipsCore decode/execute pipeline
// golden vector reader, stimulus on the falling edge
// typed compare tasks, watchdog and final report
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_mipsCore;

    localparam int maxVecs = 128;
    localparam int W = mipsPkg::wordW;

    logic         Clock;
    logic         rstN;
    logic [W-1:0] instr;
    logic         instrValid;
    logic [W-1:0] pcInc;
    logic         wbValid;
    logic         wbWrite;
    logic [4:0]   wbAddr;
    logic [W-1:0] wbData;
    logic         memWrite;
    logic [W-1:0] memAddr;
    logic [W-1:0] memWData;
    logic         redirect;
    logic [W-1:0] redirectPc;

    // one entry per golden line
    logic         vecValid      [maxVecs];
    logic [W-1:0] vecInstr      [maxVecs];
    logic [W-1:0] vecPcInc      [maxVecs];
    logic         expWbWrite    [maxVecs];
    logic [4:0]   expWbAddr     [maxVecs];
    logic [W-1:0] expWbData     [maxVecs];
    logic         expMemWrite   [maxVecs];
    logic [W-1:0] expMemAddr    [maxVecs];
    logic [W-1:0] expMemWData   [maxVecs];
    logic         expRedirect   [maxVecs];
    logic [W-1:0] expRedirectPc [maxVecs];

    int vecCount      = 0;
    int mismatchCount = 0;
    int otherErrors   = 0;
    bit loaded        = 1'b0;

    mipsCore #(
        .dmemWords(64)
    ) u_mipsCore (
        .Clock     (Clock),
        .rstN      (rstN),
        .instr     (instr),
        .instrValid(instrValid),
        .pcInc     (pcInc),
        .wbValid   (wbValid),
        .wbWrite   (wbWrite),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .memWrite  (memWrite),
        .memAddr   (memAddr),
        .memWData  (memWData),
        .redirect  (redirect),
        .redirectPc(redirectPc)
    );

    always #5 Clock = ~Clock;

    task automatic readGolden();
        int           fd;
        int           fields;
        int           lineNo;
        string        line;
        logic         v, ww, mw, rd;
        logic [4:0]   wa;
        logic [W-1:0] ins, pc, wd, ma, md, rpc;
        fd = $fopen("test/mipsCore_golden.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open test/mipsCore_golden.txt for reading");
            otherErrors++;
            return;
        end
        lineNo = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            lineNo++;
            if (line.len() == 0 || line[0] == "#") continue;
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                             v, ins, pc, ww, wa, wd, mw, ma, md, rd, rpc);
            // blank line
            if (fields <= 0) continue;
            if (fields < 11) begin
                $display("ERROR: golden line %0d holds only %0d of 11 fields", lineNo, fields);
                otherErrors++;
                continue;
            end
            if (vecCount >= maxVecs) begin
                $display("ERROR: golden file has more than %0d vectors", maxVecs);
                otherErrors++;
                break;
            end
            vecValid[vecCount]      = v;
            vecInstr[vecCount]      = ins;
            vecPcInc[vecCount]      = pc;
            expWbWrite[vecCount]    = ww;
            expWbAddr[vecCount]     = wa;
            expWbData[vecCount]     = wd;
            expMemWrite[vecCount]   = mw;
            expMemAddr[vecCount]    = ma;
            expMemWData[vecCount]   = md;
            expRedirect[vecCount]   = rd;
            expRedirectPc[vecCount] = rpc;
            vecCount++;
        end
        $fclose(fd);
    endtask

    // live instruction words on the bus during a bubble
    // the valid bit alone must keep them from acting
    function automatic logic [W-1:0] bubbleWord(input int idx);
        if (idx % 2 == 0) begin
            // sw r6, 12(r2)
            return 32'hac46000c;
        end else begin
            // jal, writes r31 and redirects
            return 32'h0c100080;
        end
    endfunction

    task automatic checkStrobe(input int idx, input string name, input logic exp,
                               input logic act);
        if (act !== exp) begin
            mismatchCount++;
            $display("MISMATCH vector %0d %s exp %h got %h", idx, name, exp, act);
        end
    endtask

    task automatic checkWb(input int idx, input logic [4:0] expAddr, input logic [W-1:0] expData,
                           input logic [4:0] actAddr, input logic [W-1:0] actData);
        if (actAddr !== expAddr) begin
            mismatchCount++;
            $display("MISMATCH vector %0d wbAddr exp %h got %h", idx, expAddr, actAddr);
        end
        if (actData !== expData) begin
            mismatchCount++;
            $display("MISMATCH vector %0d wbData exp %h got %h", idx, expData, actData);
        end
    endtask

    task automatic checkMem(input int idx, input logic [W-1:0] expAddr,
                            input logic [W-1:0] expData, input logic [W-1:0] actAddr,
                            input logic [W-1:0] actData);
        if (actAddr !== expAddr) begin
            mismatchCount++;
            $display("MISMATCH vector %0d memAddr exp %h got %h", idx, expAddr, actAddr);
        end
        if (actData !== expData) begin
            mismatchCount++;
            $display("MISMATCH vector %0d memWData exp %h got %h", idx, expData, actData);
        end
    endtask

    task automatic checkRedirect(input int idx, input logic [W-1:0] expPc,
                                 input logic [W-1:0] actPc);
        if (actPc !== expPc) begin
            mismatchCount++;
            $display("MISMATCH vector %0d redirectPc exp %h got %h", idx, expPc, actPc);
        end
    endtask

    // outputs of vector idx two cycles after it was driven
    task automatic checkVector(input int idx);
        checkStrobe(idx, "wbValid", vecValid[idx], wbValid);
        checkStrobe(idx, "wbWrite", expWbWrite[idx], wbWrite);
        if (expWbWrite[idx]) checkWb(idx, expWbAddr[idx], expWbData[idx], wbAddr, wbData);
        checkStrobe(idx, "memWrite", expMemWrite[idx], memWrite);
        if (expMemWrite[idx]) begin
            checkMem(idx, expMemAddr[idx], expMemWData[idx], memAddr, memWData);
        end
        checkStrobe(idx, "redirect", expRedirect[idx], redirect);
        if (expRedirect[idx]) checkRedirect(idx, expRedirectPc[idx], redirectPc);
    endtask

    task automatic reportCounts();
        $display("checked %0d vectors: %0d mismatches, %0d other errors",
                 vecCount, mismatchCount, otherErrors);
    endtask

    initial begin
        Clock      = 1'b0;
        rstN       = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        pcInc      = '0;
        readGolden();
        if (vecCount == 0) begin
            $display("ERROR: no vectors were read from the golden file");
            otherErrors++;
        end
        loaded = 1'b1;
        repeat (4) @(posedge Clock);
        @(negedge Clock);
        rstN = 1'b1;
        for (int cyc = 0; cyc < vecCount + 2; cyc++) begin
            @(negedge Clock);
            if (cyc >= 2) checkVector(cyc - 2);
            if (cyc < vecCount) begin
                instrValid = vecValid[cyc];
                instr      = vecValid[cyc] ? vecInstr[cyc] : bubbleWord(cyc);
                pcInc      = vecPcInc[cyc];
            end else begin
                instrValid = 1'b0;
                instr      = '0;
            end
        end
        reportCounts();
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog sized from the vector count
    initial begin
        wait (loaded);
        #((vecCount + 10) * 10);
        otherErrors++;
        $display("ERROR: timeout, the run did not end within %0d clock cycles", vecCount + 10);
        reportCounts();
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* all.f */
design/mipsPkg.sv
design/decExIf.sv
design/mipsControl.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/mipsCore.sv
test/mipsCore_sva.sv
test/tb_mipsCore.sv

/* run.sh */
#!/usr/bin/env bash
# build the mipsCore testbench with Verilator, run it, check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_mipsCore \
    --Mdir obj_dir \
    -f all.f

./obj_dir/Vtb_mipsCore 2>&1 | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed, see sim.log"
    exit 1
fi

/* test/mipsCore_golden.txt */
# valid instr pcInc | wbWrite wbAddr wbData | memWrite memAddr memWData | redirect redirectPc
# all fields hex, one instruction per line, expectations appear two cycles later
0 00000000 00400004 0 00 00000000 0 00000000 00000000 0 00000000
0 00000000 00400008 0 00 00000000 0 00000000 00000000 0 00000000
1 00a61821 0040000c 1 03 00000000 0 00000000 00000000 0 00000000
1 24011234 00400010 1 01 00001234 0 00000000 00000000 0 00000000
1 2422fff0 00400014 1 02 00001224 0 00000000 00000000 0 00000000
1 00222021 00400018 1 04 00002458 0 00000000 00000000 0 00000000
1 00442823 0040001c 1 05 ffffedcc 0 00000000 00000000 0 00000000
1 3c068765 00400020 1 06 87650000 0 00000000 00000000 0 00000000
1 34c64321 00400024 1 06 87654321 0 00000000 00000000 0 00000000
1 30a7ff0f 00400028 1 07 0000ed0c 0 00000000 00000000 0 00000000
1 38c8ffff 0040002c 1 08 8765bcde 0 00000000 00000000 0 00000000
1 00c54824 00400030 1 09 87654100 0 00000000 00000000 0 00000000
1 00265025 00400034 1 0a 87655335 0 00000000 00000000 0 00000000
1 00ca5826 00400038 1 0b 00001014 0 00000000 00000000 0 00000000
1 01606027 0040003c 1 0c ffffefeb 0 00000000 00000000 0 00000000
1 00a1682a 00400040 1 0d 00000001 0 00000000 00000000 0 00000000
1 282e1000 00400044 1 0e 00000000 0 00000000 00000000 0 00000000
1 00067900 00400048 1 0f 76543210 0 00000000 00000000 0 00000000
1 00068202 0040004c 1 10 00876543 0 00000000 00000000 0 00000000
1 00068a03 00400050 1 11 ff876543 0 00000000 00000000 0 00000000
0 00000000 00400054 0 00 00000000 0 00000000 00000000 0 00000000
1 70a69002 00400058 1 12 60b60b4c 0 00000000 00000000 0 00000000
1 724b9802 0040005c 1 13 eeeda1f0 0 00000000 00000000 0 00000000
1 ac46000c 00400060 0 00 00000000 1 00001230 87654321 0 00000000
1 ac130010 00400064 0 00 00000000 1 00000010 eeeda1f0 0 00000000
1 8c54000c 00400068 1 14 87654321 0 00000000 00000000 0 00000000
1 8c150010 0040006c 1 15 eeeda1f0 0 00000000 00000000 0 00000000
1 02b4b021 00400070 1 16 7652e511 0 00000000 00000000 0 00000000
1 12860003 00400074 0 00 00000000 0 00000000 00000000 1 00400080
1 16860005 00400078 0 00 00000000 0 00000000 00000000 0 00000000
1 24170001 0040007c 1 17 00000001 0 00000000 00000000 0 00000000
1 16e0fffe 00400080 0 00 00000000 0 00000000 00000000 1 00400078
1 10220001 00400084 0 00 00000000 0 00000000 00000000 0 00000000
1 08100040 00400088 0 00 00000000 0 00000000 00000000 1 00400100
1 0c100080 0040008c 1 1f 00400090 0 00000000 00000000 1 00400200
1 03e0c021 00400090 1 18 00400090 0 00000000 00000000 0 00000000
1 00000000 00400094 0 00 00000000 0 00000000 00000000 0 00000000
1 00220021 00400098 0 00 00000000 0 00000000 00000000 0 00000000
0 00000000 0040009c 0 00 00000000 0 00000000 00000000 0 00000000
